//--- test/fdiv_stimulus.txt
# Hex fields. D tag dividend divisor quotient, E addr dividend wdata (expects pslverr)
# S cycles to hold resultReady low after draining, Q status read of queued count
D 1 8000 8000 10000
D 2 ffff ffff 10000
D 3 8000 ffff 08000
D 4 ffff 8000 1fffe
D 5 c000 8000 18000
D 6 8000 c000 0aaaa
D 7 a000 c000 0d555
E 4 8000 00014000
E 4 4000 00028000
E c 8000 00038000
D 8 9000 9000 10000
S 3c
D 9 8000 8000 10000
D a e000 8000 1c000
D b 8000 a000 0cccc
D c ffff 8001 1fffa
D d 8001 ffff 08001
Q
D e 8000 8000 10000
D f 9999 cccc 0c000
D 0 aaaa ffff 0aaaa

//--- vlog.f
+incdir+common
common/fdivPkg.sv
verilog/apbDivFrontend.sv
verilog/divReqFifo.sv
divider/radix4Stage.sv
divider/divIterator.sv
verilog/fdivTop.sv
test/fdivTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fdivTb -f vlog.f -o fdivSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/fdivSim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0

//--- test/fdivTb.sv
`include "fdiv_macros.svh"

module fdivTb;
  import fdivPkg::*;

  localparam int          PERIOD = 40;
  localparam int          DRIVE  = 2;       // Input skew after the rising edge
  localparam int          NRAND  = 200;     // Random divisions after the file
  localparam int          CW     = $clog2(`FDIV_FIFO_DEPTH+1);
  localparam logic [31:0] SEED   = 32'h770e_5dad;

  logic        pclk, rstN, psel, penable, pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr, resultValid, resultReady;
  divResult_t  result;

  divResult_t  expQ[$];                     // Owed results, in write order
  string       lines[$];
  int          nItems;
  int          accepted, done, stallCycles, holdCnt;
  bit          randGaps;                    // Random sink gaps on or off
  logic [31:0] rngOp, rngGap;

  fdivTop dut (
    .pclk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .resultValid, .result, .resultReady
  );

  initial begin
    pclk = 1'b0;
    forever #(PERIOD/2) pclk = ~pclk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkResult(input divResult_t got, input divResult_t exp);
    if (got !== exp)
      abortRun($sformatf("Error at %0t: tag %h quotient %h, expected tag %h quotient %h",
                         $time, got.tag, got.quotient, exp.tag, exp.quotient));
  endtask

  task automatic checkResp(input logic got, input logic exp, input string what);
    if (got !== exp)
      abortRun($sformatf("Error at %0t: pslverr %b on %s, expected %b", $time, got, what, exp));
  endtask

  task automatic checkCount(input logic [CW-1:0] got, input logic [CW-1:0] exp);
    if (got !== exp)
      abortRun($sformatf("Error at %0t: status count %0d, expected %0d", $time, got, exp));
  endtask

  // One APB transfer, setup then access until pready
  task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                         output logic err, output logic [31:0] rdata);
    @(posedge pclk);
    #DRIVE;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk);
    #DRIVE;
    penable = 1'b1;
    @(negedge pclk);
    while (pready !== 1'b1) begin           // Full FIFO holds the write
      stallCycles++;
      @(negedge pclk);
    end
    err   = pslverr;
    rdata = prdata;
    @(posedge pclk);
    #DRIVE;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic runDivision(input logic [`FDIV_TAGW-1:0] tag, input logic [15:0] dvd,
                             input logic [15:0] dvs, input logic [16:0] q);
    logic        err;
    logic [31:0] rd;
    divResult_t  exp;
    exp.tag      = tag;
    exp.quotient = q;
    apbXfer(1'b1, `FDIV_ADDR_DIVIDEND, 32'(dvd), err, rd);
    checkResp(err, 1'b0, "dividend write");
    apbXfer(1'b1, `FDIV_ADDR_DIVISOR, {12'h0, tag, dvs}, err, rd);
    checkResp(err, 1'b0, "divisor write");
    accepted++;
    expQ.push_back(exp);
  endtask

  // Bad operand or address, must be refused with no result
  task automatic errorCase(input logic [3:0] addr, input logic [15:0] dvd,
                           input logic [31:0] data);
    logic        err;
    logic [31:0] rd;
    apbXfer(1'b1, `FDIV_ADDR_DIVIDEND, 32'(dvd), err, rd);
    checkResp(err, 1'b0, "dividend write");
    apbXfer(1'b1, addr, data, err, rd);
    checkResp(err, 1'b1, "rejected write");
  endtask

  task automatic statusCheck;
    logic        err;
    logic [31:0] rd;
    int          inFlight;
    apbXfer(1'b0, `FDIV_ADDR_STATUS, '0, err, rd);
    checkResp(err, 1'b0, "status read");
    inFlight = (accepted > done) ? 1 : 0;   // Iterator holds one
    checkCount(rd[CW-1:0], CW'(accepted - done - inFlight));
  endtask

  task automatic waitDrain;
    while (expQ.size() != 0) @(posedge pclk);
  endtask

  ////////////////////////////////////////
  // Result sink and monitor
  ////////////////////////////////////////

  initial begin : sink
    wait (rstN);
    forever begin
      @(posedge pclk);
      #DRIVE;
      rngGap = xorshift32(rngGap);
      if (holdCnt > 0) begin
        holdCnt--;
        resultReady = 1'b0;
      end else begin
        resultReady = randGaps ? (rngGap[1:0] != 2'b00) : 1'b1;
      end
    end
  end

  // Sampled mid-cycle, handshake takes effect on the next edge
  initial begin : monitor
    divResult_t held;
    bit         stalled;
    stalled = 1'b0;
    wait (rstN);
    forever begin
      @(negedge pclk);
      if (stalled) begin
        if (resultValid !== 1'b1) abortRun("resultValid dropped before the result was taken");
        checkResult(result, held);          // Must not move while stalled
      end
      stalled = resultValid && !resultReady;
      held    = result;
      if (resultValid && resultReady) begin
        if (expQ.size() == 0) abortRun("DUT produced a result nobody asked for");
        checkResult(result, expQ.pop_front());
        done++;
      end
    end
  end

  initial begin : watchdog
    wait (nItems != 0);
    #((nItems + NRAND) * 20 * PERIOD);
    abortRun("Watchdog expired before all results came back");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : main
    int          fd, n;
    byte         kind;
    string       line;
    logic [31:0] f0, f1, f2, f3;
    logic [15:0] dvd, dvs;
    logic [31:0] num;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    resultReady = 1'b0;
    rstN        = 1'b0;
    randGaps    = 1'b0;
    holdCnt     = 0;
    rngOp       = SEED;
    rngGap      = xorshift32(SEED);         // Separate stream for the sink
    fd = $fopen("test/fdiv_stimulus.txt", "r");
    if (fd == 0) abortRun("Cannot open test/fdiv_stimulus.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") lines.push_back(line);
    end
    $fclose(fd);
    nItems = lines.size();
    repeat (3) @(posedge pclk);
    #DRIVE;
    rstN = 1'b1;

    foreach (lines[i]) begin
      kind = lines[i].getc(0);
      n = $sscanf(lines[i].substr(1, lines[i].len() - 1), "%h %h %h %h", f0, f1, f2, f3);
      case (kind)
        "D": runDivision(f0[3:0], f1[15:0], f2[15:0], f3[16:0]);
        "E": errorCase(f0[3:0], f1[15:0], f2);
        "S": begin
          waitDrain();
          holdCnt = int'(f0);               // Sink off, queue fills up
        end
        "Q": statusCheck();
        default: abortRun($sformatf("Unknown stimulus line: %s", lines[i]));
      endcase
    end

    // Random normalized operands, floor rule for expected quotient
    randGaps = 1'b1;
    for (int i = 0; i < NRAND; i++) begin
      rngOp = xorshift32(rngOp);
      dvd   = {1'b1, rngOp[14:0]};
      dvs   = {1'b1, rngOp[30:16]};
      num   = {dvd, 16'h0};
      runDivision(i[3:0], dvd, dvs, 17'(num / {16'h0, dvs}));
    end

    waitDrain();
    if (stallCycles == 0) begin
      abortRun("A full FIFO never held off a divisor write");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

//--- verilog/fdivTop.sv
`include "fdiv_macros.svh"

module fdivTop (
  input  logic                pclk,
  input  logic                rstN,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [3:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                resultValid,
  output fdivPkg::divResult_t result,
  input  logic                resultReady
);
  import fdivPkg::*;

  logic                                  push, pop;
  logic                                  full, empty;
  logic [$clog2(`FDIV_FIFO_DEPTH+1)-1:0] count;
  divReq_t                               pushReq, popReq;

  // Host side
  apbDivFrontend frontend (
    .pclk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .full, .count, .prdata, .pready, .pslverr, .push, .pushReq
  );

  divReqFifo fifo (.pclk, .rstN, .push, .pushReq, .pop, .popReq, .full, .empty, .count);

  // One division in flight
  divIterator iterator (.pclk, .rstN, .empty, .popReq, .resultReady, .pop, .resultValid, .result);

endmodule

//--- divider/divIterator.sv
`include "fdiv_macros.svh"

module divIterator (
  input  logic                pclk,
  input  logic                rstN,
  input  logic                empty,
  input  fdivPkg::divReq_t    popReq,
  input  logic                resultReady,
  output logic                pop,
  output logic                resultValid,
  output fdivPkg::divResult_t result
);
  import fdivPkg::*;

  localparam int CNTW = $clog2(`FDIV_ITER);

  divState_t           state, stateNext;
  logic [CNTW-1:0]     digitCnt;
  divReq_t             reqReg;          // Request under way
  divResult_t          resultReg;
  logic [`FDIV_RW-1:0] ws, wc;          // Q4.16 carry-save residual
  logic [`FDIV_RW-1:0] wsNext, wcNext;
  logic [`FDIV_RW-1:0] dStage;          // Divisor in residual format
  logic [`FDIV_RW-1:0] wSum;
  logic [`FDIV_QW-1:0] u, um;           // Quotient and quotient minus one ulp
  logic [`FDIV_QW-1:0] uNext, umNext;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  assign pop = (state == IDLE) && !empty;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE:    if (!empty) stateNext = LOAD;
      LOAD:    stateNext = ITERATE;
      ITERATE: if (digitCnt == CNTW'(`FDIV_ITER - 1)) stateNext = CORRECT;
      CORRECT: stateNext = DONE;
      DONE:    if (resultReady) stateNext = IDLE;   // Stream handshake
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      state    <= IDLE;
      digitCnt <= '0;
    end else begin
      state <= stateNext;
      if (state == LOAD)         digitCnt <= '0;
      else if (state == ITERATE) digitCnt <= digitCnt + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  assign dStage = {{(`FDIV_RW-`FDIV_OPW-1){1'b0}}, reqReg.divisor, 1'b0};
  assign wSum   = ws + wc;              // Final residual, sign picks u or um

  always_ff @(posedge pclk) begin
    if (pop) reqReg <= popReq;          // Head leaves the FIFO on this edge
    case (state)
      LOAD: begin
        // Residual starts at the dividend, first digit has unit weight
        ws <= {{(`FDIV_RW-`FDIV_OPW-1){1'b0}}, reqReg.dividend, 1'b0};
        wc <= '0;
        u  <= '0;
        um <= '0;
      end
      ITERATE: begin
        ws <= wsNext;
        wc <= wcNext;
        u  <= uNext;
        um <= umNext;
      end
      CORRECT: begin
        resultReg.tag      <= reqReg.tag;
        resultReg.quotient <= wSum[`FDIV_RW-1] ? um[`FDIV_OPW:0] : u[`FDIV_OPW:0];
      end
      default: ;
    endcase
  end

  radix4Stage stage (
    .ws, .wc, .d(dStage), .u, .um,
    .wsNext, .wcNext, .uNext, .umNext
  );

  assign resultValid = (state == DONE);
  assign result      = resultReg;

  // Result held steady while the sink stalls
  resultHeld: assert property (@(posedge pclk) disable iff (!rstN)
    resultValid && !resultReady |=> resultValid && $stable(result))
    else $error("result dropped or changed before transfer");

endmodule

//--- divider/radix4Stage.sv
`include "fdiv_macros.svh"

module radix4Stage (
  input  logic [`FDIV_RW-1:0] ws,       // Q4.16
  input  logic [`FDIV_RW-1:0] wc,       // Q4.16
  input  logic [`FDIV_RW-1:0] d,        // Q4.16, leading one at integer bit 0
  input  logic [`FDIV_QW-1:0] u,
  input  logic [`FDIV_QW-1:0] um,
  output logic [`FDIV_RW-1:0] wsNext,
  output logic [`FDIV_RW-1:0] wcNext,
  output logic [`FDIV_QW-1:0] uNext,
  output logic [`FDIV_QW-1:0] umNext
);
  import fdivPkg::*;

  qDigit_t             digit;
  logic [2:0]          dMsbs;           // U0.3 after the leading one
  logic signed [7:0]   wEst;            // Q4.4 residual estimate
  logic signed [7:0]   mk2, mk1, mk0, mkm1;
  logic [`FDIV_RW-1:0] dSel;
  logic [`FDIV_RW-1:0] sumBits;
  logic [`FDIV_RW-1:0] majBits;
  logic                carryIn;

  ////////////////////////////////////////
  // Digit selection
  ////////////////////////////////////////

  assign dMsbs = d[`FDIV_RW-5:`FDIV_RW-7];
  assign wEst  = ws[`FDIV_RW-1:`FDIV_RW-8] + wc[`FDIV_RW-1:`FDIV_RW-8];

  // Thresholds in sixteenths
  always_comb begin
    case (dMsbs)
      3'd0:    begin mk2 = 8'sd24; mk1 = 8'sd8;  mk0 = -8'sd8;  mkm1 = -8'sd26; end
      3'd1:    begin mk2 = 8'sd28; mk1 = 8'sd8;  mk0 = -8'sd12; mkm1 = -8'sd30; end
      3'd2:    begin mk2 = 8'sd30; mk1 = 8'sd8;  mk0 = -8'sd12; mkm1 = -8'sd32; end
      3'd3:    begin mk2 = 8'sd32; mk1 = 8'sd8;  mk0 = -8'sd12; mkm1 = -8'sd36; end
      3'd4:    begin mk2 = 8'sd36; mk1 = 8'sd12; mk0 = -8'sd16; mkm1 = -8'sd40; end
      3'd5:    begin mk2 = 8'sd40; mk1 = 8'sd12; mk0 = -8'sd16; mkm1 = -8'sd40; end
      3'd6:    begin mk2 = 8'sd40; mk1 = 8'sd16; mk0 = -8'sd16; mkm1 = -8'sd44; end
      default: begin mk2 = 8'sd48; mk1 = 8'sd16; mk0 = -8'sd16; mkm1 = -8'sd48; end
    endcase
    if (wEst >= mk2)       digit = DIG_P2;
    else if (wEst >= mk1)  digit = DIG_P1;
    else if (wEst >= mk0)  digit = DIG_Z;
    else if (wEst >= mkm1) digit = DIG_M1;
    else                   digit = DIG_M2;
  end

  // Multiplexer below relies on a single active digit
  always_comb begin
    assert ($onehot0(digit)) else $error("quotient digit not one-hot");
  end

  ////////////////////////////////////////
  // Residual update
  ////////////////////////////////////////

  always_comb begin
    case (digit)
      DIG_P2:  dSel = ~(d << 1);        // Subtract 2d
      DIG_P1:  dSel = ~d;
      DIG_M1:  dSel = d;
      DIG_M2:  dSel = d << 1;
      default: dSel = '0;
    endcase
  end

  assign carryIn = (digit == DIG_P2) | (digit == DIG_P1);   // Completes two's complement

  // Carry-save add, then scale by the radix
  assign sumBits = ws ^ wc ^ dSel;
  assign majBits = (ws & wc) | (ws & dSel) | (wc & dSel);
  assign wsNext  = sumBits << 2;
  assign wcNext  = {majBits[`FDIV_RW-2:0], carryIn} << 2;

  // On-the-fly conversion, um tracks u minus one ulp
  always_comb begin
    case (digit)
      DIG_P2:  begin uNext = {u[`FDIV_QW-3:0], 2'b10};  umNext = {u[`FDIV_QW-3:0], 2'b01};  end
      DIG_P1:  begin uNext = {u[`FDIV_QW-3:0], 2'b01};  umNext = {u[`FDIV_QW-3:0], 2'b00};  end
      DIG_M1:  begin uNext = {um[`FDIV_QW-3:0], 2'b11}; umNext = {um[`FDIV_QW-3:0], 2'b10}; end
      DIG_M2:  begin uNext = {um[`FDIV_QW-3:0], 2'b10}; umNext = {um[`FDIV_QW-3:0], 2'b01}; end
      default: begin uNext = {u[`FDIV_QW-3:0], 2'b00};  umNext = {um[`FDIV_QW-3:0], 2'b11}; end
    endcase
  end

endmodule

//--- verilog/divReqFifo.sv
`include "fdiv_macros.svh"

module divReqFifo (
  input  logic                                  pclk,
  input  logic                                  rstN,
  input  logic                                  push,
  input  fdivPkg::divReq_t                      pushReq,
  input  logic                                  pop,
  output fdivPkg::divReq_t                      popReq,
  output logic                                  full,
  output logic                                  empty,
  output logic [$clog2(`FDIV_FIFO_DEPTH+1)-1:0] count
);
  import fdivPkg::*;

  localparam int DEPTH = `FDIV_FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);

  divReq_t       mem [DEPTH];
  logic [PW-1:0] wrPtr;
  logic [PW-1:0] rdPtr;

  // Circular increment, depth need not be a power of two
  function automatic logic [PW-1:0] ptrInc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge pclk) begin
    if (push) mem[wrPtr] <= pushReq;
  end

  always_ff @(posedge pclk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) wrPtr <= ptrInc(wrPtr);
      if (pop)  rdPtr <= ptrInc(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Idle or simultaneous push and pop
      endcase
    end
  end

  assign popReq = mem[rdPtr];   // Fall-through head
  assign full   = (count == DEPTH);
  assign empty  = (count == 0);

  // Producer honours full, consumer honours empty
  pushNotFull: assert property (@(posedge pclk) disable iff (!rstN) push |-> !full)
    else $error("request FIFO overflow");
  popNotEmpty: assert property (@(posedge pclk) disable iff (!rstN) pop |-> !empty)
    else $error("request FIFO underflow");

endmodule

//--- verilog/apbDivFrontend.sv
`include "fdiv_macros.svh"

module apbDivFrontend (
  input  logic                                  pclk,
  input  logic                                  rstN,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [3:0]                            paddr,
  input  logic [31:0]                           pwdata,
  input  logic                                  full,
  input  logic [$clog2(`FDIV_FIFO_DEPTH+1)-1:0] count,
  output logic [31:0]                           prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic                                  push,
  output fdivPkg::divReq_t                      pushReq
);
  import fdivPkg::*;

  apbReg_t              regSel;
  logic                 access;       // Access phase of a transfer
  logic                 divisorWr;
  logic                 badOperand;   // Leading bit missing on either operand
  logic                 stall;
  logic [`FDIV_OPW-1:0] dividendReg;

  ////////////////////////////////////////
  // Address decode and handshake
  ////////////////////////////////////////

  always_comb begin
    case (paddr)
      `FDIV_ADDR_DIVIDEND: regSel = REG_DIVIDEND;
      `FDIV_ADDR_DIVISOR:  regSel = REG_DIVISOR;
      `FDIV_ADDR_STATUS:   regSel = REG_STATUS;
      default:             regSel = REG_NONE;
    endcase
  end

  assign access     = psel & penable;
  assign divisorWr  = access & pwrite & (regSel == REG_DIVISOR);
  assign badOperand = ~pwdata[`FDIV_OPW-1] | ~dividendReg[`FDIV_OPW-1];
  assign stall      = divisorWr & ~badOperand & full;   // Hold until FIFO has room

  assign pready  = access & ~stall;
  assign pslverr = access & ((regSel == REG_NONE) | (divisorWr & badOperand));

  // Divisor write launches the request
  assign push             = divisorWr & ~badOperand & ~full;
  assign pushReq.tag      = pwdata[`FDIV_OPW+`FDIV_TAGW-1:`FDIV_OPW];
  assign pushReq.dividend = dividendReg;
  assign pushReq.divisor  = pwdata[`FDIV_OPW-1:0];

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // Cleared so a divisor write before any dividend is rejected
  always_ff @(posedge pclk) begin
    if (!rstN) begin
      dividendReg <= '0;
    end else if (access && pwrite && regSel == REG_DIVIDEND) begin
      dividendReg <= pwdata[`FDIV_OPW-1:0];
    end
  end

  always_comb begin
    case (regSel)
      REG_DIVIDEND: prdata = 32'(dividendReg);
      REG_STATUS:   prdata = 32'(count);        // Queue occupancy
      default:      prdata = '0;
    endcase
  end

endmodule

//--- common/fdivPkg.sv
`include "fdiv_macros.svh"

package fdivPkg;

  // Queued division request
  typedef struct packed {
    logic [`FDIV_TAGW-1:0] tag;
    logic [`FDIV_OPW-1:0]  dividend;   // U1.15
    logic [`FDIV_OPW-1:0]  divisor;    // U1.15
  } divReq_t;

  // Result on the output stream
  typedef struct packed {
    logic [`FDIV_TAGW-1:0] tag;
    logic [`FDIV_OPW:0]    quotient;   // U1.16
  } divResult_t;

  // Iterator FSM
  typedef enum logic [2:0] {
    IDLE, LOAD, ITERATE, CORRECT, DONE
  } divState_t;

  // Decoded APB address
  typedef enum logic [1:0] {
    REG_DIVIDEND, REG_DIVISOR, REG_STATUS, REG_NONE
  } apbReg_t;

  // Quotient digit, one-hot {+2, +1, -1, -2}, all zero for 0
  typedef enum logic [3:0] {
    DIG_M2 = 4'b0001,
    DIG_M1 = 4'b0010,
    DIG_Z  = 4'b0000,
    DIG_P1 = 4'b0100,
    DIG_P2 = 4'b1000
  } qDigit_t;

endpackage

//--- common/fdiv_macros.svh
`ifndef FDIV_MACROS_SVH
`define FDIV_MACROS_SVH

// Operand and datapath widths
`define FDIV_OPW            16   // U1.15 operands
`define FDIV_QW             18   // 9 digits of 2 bits
`define FDIV_RW             20   // Q4.16 carry-save residual

// Recurrence length
`define FDIV_ITER           9

// Request queue
`define FDIV_FIFO_DEPTH     4
`define FDIV_TAGW           4

// APB register map
`define FDIV_ADDR_DIVIDEND  4'h0
`define FDIV_ADDR_DIVISOR   4'h4
`define FDIV_ADDR_STATUS    4'h8

`endif
